/* build.f */
+incdir+hdl
hdl/sram_pkg.sv
hdl/sram_ifs.sv
hdl/sram_2k8.sv
hdl/sram_arbiter.sv
hdl/page_translator.sv
hdl/host_port.sv
hdl/mmu_sram_top.sv
verif/tb_checker.sv
verif/sram_asserts.sv
verif/tb_top.sv

/* Makefile */
# Verilator build and run for the shared RAM testbench

SRCS = $(filter-out +incdir+%,$(shell cat build.f)) hdl/sram_consts.svh

obj_dir/Vtb_top: build.f $(SRCS)
	verilator --binary --timing --assert -f build.f --top-module tb_top

run: obj_dir/Vtb_top
	obj_dir/Vtb_top > sim.log 2>&1; cat sim.log
	grep -qx "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* verif/tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench top for the shared RAM DUT
// Clock, reset, random table load,
// stimulus table applied in a loop
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module tb_top
  import sram_pkg::*;
();

  localparam int TIMEOUT_CYC = 40;  // Per wait
  localparam int N_ROWS      = 12;

  typedef enum logic [2:0] {
    OP_HWR,      // Host write
    OP_HRD,      // Host read, byte checked
    OP_XL,       // Translate, entry checked
    OP_BOTH,     // Host read and translate strobed together
    OP_HWR_BUSY  // Host write, second strobe while busy
  } op_e;

  typedef struct packed {
    op_e        kind;
    sram_addr_t addr;      // Host address
    vpage_t     page;      // Virtual page
    sram_data_t data;      // Host write byte
    sram_data_t exp_byte;  // Expected read byte
    pte_t       exp_pte;   // Expected entry
  } row_t;

  logic       clk;
  logic       reset_n;
  logic       xlate_strobe;
  vpage_t     xlate_vpage;
  logic       xlate_busy;
  logic       xlate_done;
  logic [6:0] xlate_ppage;
  logic       xlate_fault;
  logic       host_strobe;
  logic       host_we;
  sram_addr_t host_addr;
  sram_data_t host_wdata;
  logic       host_busy;
  logic       host_done;
  sram_data_t host_rdata;
  sram_data_t exp_byte;
  pte_t       exp_pte;
  logic       order_chk;
  int         checks;
  int         errors;
  int         timeouts;
  row_t       rows [0:N_ROWS-1];

  mmu_sram_top mmu_sram_top_inst (.*);

  tb_checker tb_checker_inst (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  task automatic next_cycle();
    @(posedge clk);
    #1;  // Drive point
  endtask

  task automatic start_host(input logic we, input sram_addr_t a, input sram_data_t d);
    host_strobe = 1'b1;
    host_we     = we;
    host_addr   = a;
    host_wdata  = d;
  endtask

  task automatic start_xlate(input vpage_t p);
    xlate_strobe = 1'b1;
    xlate_vpage  = p;
  endtask

  task automatic release_strobes();
    next_cycle();  // Strobe captured at this edge
    host_strobe  = 1'b0;
    xlate_strobe = 1'b0;
  endtask

  task automatic end_run();
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  // Wait for the done pulses asked for
  task automatic wait_done(input logic want_host, input logic want_xl, input string what);
    logic got_h;
    logic got_x;
    int   n;
    got_h = !want_host;
    got_x = !want_xl;
    n     = 0;
    while (!(got_h && got_x) && n < TIMEOUT_CYC) begin
      next_cycle();
      if (host_done) got_h = 1'b1;
      if (xlate_done) got_x = 1'b1;
      n++;
    end
    if (!(got_h && got_x)) begin
      $display("Timeout: no done for %s within %0d cycles", what, TIMEOUT_CYC);
      timeouts++;  // Stops the remaining stimulus
    end else begin
      next_cycle();  // Checker samples the pulse with this row's expectations
    end
  endtask

  // Random entries for the first pages, each translated right after
  task automatic load_random_table();
    sram_data_t b;
    for (int i = 0; i < `HOST_TEST_W && timeouts == 0; i++) begin
      b       = sram_data_t'($urandom);
      exp_pte = pte_t'(b);
      start_host(1'b1, `PT_BASE + 11'(i), b);
      release_strobes();
      wait_done(1'b1, 1'b0, "table load write");
      if (timeouts == 0) begin
        start_xlate(vpage_t'(i));
        release_strobes();
        wait_done(1'b0, 1'b1, "table load translate");
      end
    end
  endtask

  task automatic run_row(input row_t r);
    exp_byte = r.exp_byte;
    exp_pte  = r.exp_pte;
    case (r.kind)
      OP_HWR: begin
        start_host(1'b1, r.addr, r.data);
        release_strobes();
        wait_done(1'b1, 1'b0, "host write");
      end
      OP_HRD: begin
        start_host(1'b0, r.addr, 8'h00);
        release_strobes();
        wait_done(1'b1, 1'b0, "host read");
      end
      OP_XL: begin
        start_xlate(r.page);
        release_strobes();
        wait_done(1'b0, 1'b1, "translate");
      end
      OP_BOTH: begin
        order_chk = 1'b1;
        start_host(1'b0, r.addr, 8'h00);
        start_xlate(r.page);
        release_strobes();
        wait_done(1'b1, 1'b1, "host read with translate");
        order_chk = 1'b0;
      end
      OP_HWR_BUSY: begin
        start_host(1'b1, r.addr, r.data);
        next_cycle();                      // First command taken
        start_host(1'b1, r.addr, ~r.data); // Lands while busy
        release_strobes();
        wait_done(1'b1, 1'b0, "host write with busy strobe");
      end
      default: ;
    endcase
  endtask

  initial begin
    reset_n      = 1'b0;
    xlate_strobe = 1'b0;
    xlate_vpage  = '0;
    host_strobe  = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    exp_byte     = '0;
    exp_pte      = '0;
    order_chk    = 1'b0;
    timeouts     = 0;
    void'($urandom(32'he48ef55d));
    // kind, addr, page, data, exp_byte, exp_pte
    rows[0]  = '{OP_HWR, 11'h012, 8'h00, 8'h5a, 8'h00, 8'h00};
    rows[1]  = '{OP_HRD, 11'h012, 8'h00, 8'h00, 8'h5a, 8'h00};
    rows[2]  = '{OP_HWR, 11'h3ff, 8'h00, 8'hc3, 8'h00, 8'h00};
    rows[3]  = '{OP_HRD, 11'h3ff, 8'h00, 8'h00, 8'hc3, 8'h00};
    rows[4]  = '{OP_HWR, `PT_BASE + 11'h020, 8'h00, 8'h95, 8'h00, 8'h00};  // Valid entry
    rows[5]  = '{OP_XL, 11'h000, 8'h20, 8'h00, 8'h00, 8'h95};
    rows[6]  = '{OP_HWR, `PT_BASE + 11'h021, 8'h00, 8'h33, 8'h00, 8'h00};  // Valid bit clear
    rows[7]  = '{OP_XL, 11'h000, 8'h21, 8'h00, 8'h00, 8'h33};
    rows[8]  = '{OP_BOTH, 11'h012, 8'h20, 8'h00, 8'h5a, 8'h95};
    rows[9]  = '{OP_HWR_BUSY, 11'h0a0, 8'h00, 8'h77, 8'h00, 8'h00};
    rows[10] = '{OP_HRD, 11'h0a0, 8'h00, 8'h00, 8'h77, 8'h00};      // First write only
    rows[11] = '{OP_BOTH, 11'h3ff, 8'h21, 8'h00, 8'hc3, 8'h33};
    repeat (10) @(posedge clk);
    #1 reset_n = 1'b1;
    repeat (3) next_cycle();  // Idle outputs watched by the checker
    load_random_table();
    for (int i = 0; i < N_ROWS && timeouts == 0; i++) begin
      run_row(rows[i]);
    end
    end_run();
  end

endmodule

/* verif/sram_asserts.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Arbiter assertions, bound to sram_arbiter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module sram_asserts (
  input logic clk,
  input logic reset_n,
  input logic gnt_xl,
  input logic gnt_host,
  input logic xl_we,        // Translator request direction
  input logic host_we,      // Host request direction
  input logic xl_rvalid,
  input logic host_rvalid,
  input logic cs_n,
  input logic oe_n,
  input logic w_n
);

  // One grant per cycle
  a_one_gnt: assert property (@(posedge clk) disable iff (!reset_n)
      !(gnt_xl && gnt_host))
    else $error("Both clients granted in one cycle");

  // Read data goes only to the client granted a read the cycle before
  a_xl_rvalid_src: assert property (@(posedge clk) disable iff (!reset_n)
      xl_rvalid |-> $past(gnt_xl && !xl_we))
    else $error("Translator rdata_valid without its read grant in the cycle before");

  a_host_rvalid_src: assert property (@(posedge clk) disable iff (!reset_n)
      host_rvalid |-> $past(gnt_host && !host_we))
    else $error("Host rdata_valid without its read grant in the cycle before");

  // Every read grant returns data to the same client
  a_xl_rvalid_ret: assert property (@(posedge clk) disable iff (!reset_n)
      (gnt_xl && !xl_we) |=> xl_rvalid)
    else $error("Translator read grant not followed by its rdata_valid");

  a_host_rvalid_ret: assert property (@(posedge clk) disable iff (!reset_n)
      (gnt_host && !host_we) |=> host_rvalid)
    else $error("Host read grant not followed by its rdata_valid");

  // RAM idle when reset lifts
  a_idle_reset: assert property (@(posedge clk)
      $rose(reset_n) |-> (cs_n && oe_n && w_n))
    else $error("RAM controls active right after reset");

endmodule

bind sram_arbiter sram_asserts sram_asserts_inst (
  .clk         (clk),
  .reset_n     (reset_n),
  .gnt_xl      (gnt_xl),
  .gnt_host    (gnt_host),
  .xl_we       (xl.we),
  .host_we     (host.we),
  .xl_rvalid   (xl.rdata_valid),
  .host_rvalid (host.rdata_valid),
  .cs_n        (bus.cs_n),
  .oe_n        (bus.oe_n),
  .w_n         (bus.w_n)
);

/* verif/tb_checker.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Result checker for the shared RAM DUT
// Reference image, compares at done,
// check and error counters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module tb_checker
  import sram_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       host_strobe,
  input  logic       host_we,
  input  sram_addr_t host_addr,
  input  sram_data_t host_wdata,
  input  logic       host_busy,
  input  logic       host_done,
  input  sram_data_t host_rdata,
  input  logic       xlate_strobe,
  input  vpage_t     xlate_vpage,
  input  logic       xlate_busy,
  input  logic       xlate_done,
  input  logic [6:0] xlate_ppage,
  input  logic       xlate_fault,
  input  sram_data_t exp_byte,   // Expected host read byte
  input  pte_t       exp_pte,    // Expected page entry
  input  logic       order_chk,  // Translator must be done first
  output int         checks,
  output int         errors
);

  sram_data_t image [0:(1<<`SRAM_AW)-1];  // Reference memory
  logic       known [0:(1<<`SRAM_AW)-1];  // Written at least once
  logic       h_pend;                     // Accepted host command open
  logic       h_we_q;
  sram_addr_t h_addr_q;
  sram_data_t h_data_q;
  logic       x_pend;                     // Accepted translate open
  sram_addr_t x_addr_q;                   // Its entry address
  logic       strobe_seen;
  pte_t       ref_pte;
  int         n_checks = 0;
  int         n_errors = 0;

  assign checks = n_checks;
  assign errors = n_errors;

  task automatic compare(input string sig, input logic [7:0] got, input logic [7:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Fail t=%0t %s got %02h exp %02h", $time, sig, got, exp);
    end
  endtask

  // Outputs change on NBA, so values seen here belong to the previous cycle
  always @(posedge clk) begin
    if (!reset_n) begin
      h_pend      = 1'b0;
      x_pend      = 1'b0;
      strobe_seen = 1'b0;
      for (int i = 0; i < (1 << `SRAM_AW); i++) begin
        known[i] = 1'b0;
      end
    end else begin
      if (!strobe_seen) begin  // Quiet outputs until the first command
        compare("busy_done", {4'h0, host_busy, host_done, xlate_busy, xlate_done}, 8'h00);
      end
      // Translator result, before the host so equal cycles pass the order check
      if (xlate_done) begin
        if (!x_pend) begin
          n_errors++;
          $display("Translator done pulsed with no translation open at %0t", $time);
        end else begin
          compare("xlate_ppage", {1'b0, xlate_ppage}, {1'b0, exp_pte.ppage});
          compare("xlate_fault", {7'h0, xlate_fault}, {7'h0, !exp_pte.valid});
          if (known[x_addr_q]) begin
            ref_pte = pte_t'(image[x_addr_q]);
            compare("xlate_ppage_image", {1'b0, xlate_ppage}, {1'b0, ref_pte.ppage});
            compare("xlate_fault_image", {7'h0, xlate_fault}, {7'h0, !ref_pte.valid});
          end
        end
        x_pend = 1'b0;
      end
      if (host_done) begin
        if (!h_pend) begin
          n_errors++;
          $display("Host done pulsed with no command open at %0t", $time);
        end else if (h_we_q) begin
          image[h_addr_q] = h_data_q;  // Mirror the write
          known[h_addr_q] = 1'b1;
        end else if (known[h_addr_q]) begin
          compare("host_rdata", host_rdata, exp_byte);
          compare("host_rdata_image", host_rdata, image[h_addr_q]);
        end
        if (order_chk && x_pend) begin
          n_errors++;
          $display("Host finished before the translator at %0t", $time);
        end
        h_pend = 1'b0;
      end
      // New commands, dropped by the DUT while busy
      if (host_strobe && !host_busy) begin
        h_pend   = 1'b1;
        h_we_q   = host_we;
        h_addr_q = host_addr;
        h_data_q = host_wdata;
      end
      if (xlate_strobe && !xlate_busy) begin
        x_pend   = 1'b1;
        x_addr_q = `PT_BASE + {3'b000, xlate_vpage};  // Entry for page v
      end
      if (host_strobe || xlate_strobe) begin
        strobe_seen = 1'b1;
      end
    end
  end

endmodule

/* hdl/mmu_sram_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top level of the shared RAM subsystem
// Translator, host port, arbiter, RAM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module mmu_sram_top
  import sram_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,

  // Page translator
  input  logic        xlate_strobe,
  input  vpage_t      xlate_vpage,
  output logic        xlate_busy,
  output logic        xlate_done,
  output logic [6:0]  xlate_ppage,
  output logic        xlate_fault,

  // Host port
  input  logic        host_strobe,
  input  logic        host_we,
  input  sram_addr_t  host_addr,
  input  sram_data_t  host_wdata,
  output logic        host_busy,
  output logic        host_done,
  output sram_data_t  host_rdata
);

  mem_req_if  xl_if ();    // Translator to arbiter
  mem_req_if  host_if ();  // Host to arbiter
  sram_bus_if bus_if ();   // Arbiter to RAM pins

  page_translator page_translator_inst (
    .clk          (clk),
    .reset_n      (reset_n),
    .xlate_strobe (xlate_strobe),
    .xlate_vpage  (xlate_vpage),
    .mem          (xl_if.client),
    .xlate_busy   (xlate_busy),
    .xlate_done   (xlate_done),
    .xlate_ppage  (xlate_ppage),
    .xlate_fault  (xlate_fault)
  );

  host_port host_port_inst (
    .clk         (clk),
    .reset_n     (reset_n),
    .host_strobe (host_strobe),
    .host_we     (host_we),
    .host_addr   (host_addr),
    .host_wdata  (host_wdata),
    .mem         (host_if.client),
    .host_busy   (host_busy),
    .host_done   (host_done),
    .host_rdata  (host_rdata)
  );

  sram_arbiter sram_arbiter_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .xl      (xl_if.arb),
    .host    (host_if.arb),
    .bus     (bus_if.master)
  );

  sram_2k8 sram_2k8_inst (
    .clk     (clk),
    .reset_n (reset_n),
    .bus     (bus_if.ram)
  );

endmodule

/* hdl/host_port.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Host port client
// External byte read and write commands
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module host_port
  import sram_pkg::*;
(
  input  logic        clk,
  input  logic        reset_n,
  input  logic        host_strobe,
  input  logic        host_we,
  input  sram_addr_t  host_addr,
  input  sram_data_t  host_wdata,
  mem_req_if.client   mem,
  output logic        host_busy,
  output logic        host_done,
  output sram_data_t  host_rdata
);

  typedef enum logic [1:0] {
    H_IDLE,   // Waiting for a strobe
    H_REQ,    // Request held until granted
    H_WDONE,  // Write stored, finish next edge
    H_RWAIT   // Waiting for read data
  } host_state_e;

  host_state_e        state_q;
  logic               cmd_we;     // Latched command
  sram_addr_t         cmd_addr;
  sram_data_t         cmd_wdata;
  logic [`SRAM_DW-1:0] rdata_q;   // Last read byte, held

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_q   <= H_IDLE;
      host_done <= 1'b0;
    end else begin
      host_done <= 1'b0;
      case (state_q)
        H_IDLE:  if (host_strobe) state_q <= H_REQ;
        H_REQ:   if (mem.gnt) state_q <= cmd_we ? H_WDONE : H_RWAIT;
        H_WDONE: begin
          state_q   <= H_IDLE;  // One cycle after the write grant
          host_done <= 1'b1;
        end
        H_RWAIT: begin
          if (mem.rdata_valid) begin
            state_q   <= H_IDLE;
            host_done <= 1'b1;
          end
        end
        default: state_q <= H_IDLE;
      endcase
    end
  end

  // Command latch, only when idle so a busy strobe is dropped
  always_ff @(posedge clk) begin
    if (state_q == H_IDLE && host_strobe) begin
      cmd_we    <= host_we;
      cmd_addr  <= host_addr;
      cmd_wdata <= host_wdata;
    end
    if (state_q == H_RWAIT && mem.rdata_valid) begin
      rdata_q <= mem.rdata;
    end
  end

  assign host_busy  = (state_q != H_IDLE);
  assign host_rdata = rdata_q;

  assign mem.req   = (state_q == H_REQ);
  assign mem.we    = cmd_we;
  assign mem.addr  = cmd_addr;
  assign mem.wdata = cmd_wdata;

endmodule

/* hdl/page_translator.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Page translator client
// Virtual page to physical page or fault
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module page_translator
  import sram_pkg::*;
(
  input  logic             clk,
  input  logic             reset_n,
  input  logic             xlate_strobe,
  input  vpage_t           xlate_vpage,
  mem_req_if.client        mem,
  output logic             xlate_busy,
  output logic             xlate_done,
  output logic [6:0]       xlate_ppage,
  output logic             xlate_fault
);

  typedef enum logic [1:0] {
    XL_IDLE,  // Waiting for a strobe
    XL_REQ,   // Read request held until granted
    XL_WAIT   // Waiting for the entry byte
  } xl_state_e;

  xl_state_e state_q;
  vpage_t    vpage_q;  // Page under translation
  pte_t      entry;    // Returned byte as an entry

  assign entry = pte_t'(mem.rdata);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state_q    <= XL_IDLE;
      xlate_done <= 1'b0;
    end else begin
      xlate_done <= 1'b0;  // Pulse by default
      case (state_q)
        XL_IDLE: begin
          if (xlate_strobe) begin
            state_q <= XL_REQ;
          end
        end
        XL_REQ: begin
          if (mem.gnt) begin
            state_q <= XL_WAIT;  // req drops next cycle
          end
        end
        XL_WAIT: begin
          if (mem.rdata_valid) begin
            state_q    <= XL_IDLE;
            xlate_done <= 1'b1;
          end
        end
        default: state_q <= XL_IDLE;
      endcase
    end
  end

  // Page latch and held results
  always_ff @(posedge clk) begin
    if (state_q == XL_IDLE && xlate_strobe) begin
      vpage_q <= xlate_vpage;
    end
    if (state_q == XL_WAIT && mem.rdata_valid) begin
      xlate_ppage <= entry.ppage;
      xlate_fault <= !entry.valid;  // Clear valid bit means fault
    end
  end

  assign xlate_busy = (state_q != XL_IDLE);  // Strobes ignored while high

  // Read-only client
  assign mem.req   = (state_q == XL_REQ);
  assign mem.we    = 1'b0;
  assign mem.addr  = sram_addr_t'(`PT_BASE + {3'b000, vpage_q});
  assign mem.wdata = '0;

endmodule

/* hdl/sram_arbiter.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fixed-priority RAM arbiter
// Translator over host, read data return
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module sram_arbiter
  import sram_pkg::*;
(
  input logic         clk,
  input logic         reset_n,
  mem_req_if.arb      xl,
  mem_req_if.arb      host,
  sram_bus_if.master  bus
);

  logic    gnt_xl;
  logic    gnt_host;
  logic    any_gnt;
  logic    sel_we;       // Direction of the granted access
  logic    rd_pend_q;    // Read data phase in this cycle
  client_e rd_client_q;  // Who owns the pending read

  // No new grant while the RAM presents read data
  assign gnt_xl   = xl.req && !rd_pend_q;
  assign gnt_host = host.req && !xl.req && !rd_pend_q;  // Translator wins ties
  assign any_gnt  = gnt_xl || gnt_host;

  assign xl.gnt   = gnt_xl;
  assign host.gnt = gnt_host;

  assign sel_we = gnt_host ? host.we : xl.we;

  // RAM pins carry the granted access in the grant cycle
  assign bus.addr  = gnt_host ? host.addr : xl.addr;
  assign bus.wdata = gnt_host ? host.wdata : xl.wdata;
  assign bus.cs_n  = !(any_gnt || rd_pend_q);
  assign bus.w_n   = !(any_gnt && sel_we);
  assign bus.oe_n  = !((any_gnt && !sel_we) || rd_pend_q);  // Held a 2nd cycle for reads

  // Remember an outstanding read and its owner
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_pend_q   <= 1'b0;
      rd_client_q <= CLIENT_XL;
    end else begin
      rd_pend_q   <= any_gnt && !sel_we;
      rd_client_q <= gnt_host ? CLIENT_HOST : CLIENT_XL;
    end
  end

  // Steer returned byte to its owner only
  assign xl.rdata_valid   = rd_pend_q && (rd_client_q == CLIENT_XL);
  assign host.rdata_valid = rd_pend_q && (rd_client_q == CLIENT_HOST);

  assign xl.rdata   = xl.rdata_valid ? bus.rdata : {`SRAM_DW{1'b0}};
  assign host.rdata = host.rdata_valid ? bus.rdata : {`SRAM_DW{1'b0}};

endmodule

/* hdl/sram_2k8.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Synchronous static RAM, byte wide
// Active-low controls, gated output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "sram_consts.svh"

module sram_2k8
  import sram_pkg::*;
#(
  parameter int ADDR_BITS = `SRAM_AW  // Depth is 2^ADDR_BITS bytes
) (
  input logic      clk,
  input logic      reset_n,
  sram_bus_if.ram  bus
);

  localparam int DEPTH = 1 << ADDR_BITS;

  logic [ADDR_BITS-1:0] word_addr;  // Bus address sized to this depth
  sram_data_t           rd_q;       // Registered read byte
  logic                 rd_sel;
  logic                 wr_sel;

  // Block RAM, no init possible at reset
  (* ram_style = "block" *) sram_data_t mem_array [0:DEPTH-1];

  assign word_addr = ADDR_BITS'(bus.addr);

  assign wr_sel = !bus.cs_n && !bus.w_n;  // Selected write
  assign rd_sel = !bus.cs_n && bus.w_n;   // Selected read

  // Write port
  always_ff @(posedge clk) begin
    if (wr_sel) begin
      mem_array[word_addr] <= bus.wdata;
    end
  end

  // Synchronous read, output register only is cleared
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rd_q <= '0;
    end else if (rd_sel) begin
      rd_q <= mem_array[word_addr];
    end
  end

  // Drive only when selected, enabled and not writing
  assign bus.rdata = (!bus.oe_n && !bus.cs_n && bus.w_n) ? rd_q : '0;

endmodule

/* hdl/sram_ifs.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Client request interface (mem_req_if)
// RAM pin interface (sram_bus_if)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

// One per client, client holds req until gnt
interface mem_req_if
  import sram_pkg::*;
();

  logic       req;          // Held until granted
  logic       we;           // 1 = write, 0 = read
  sram_addr_t addr;
  sram_data_t wdata;
  logic       gnt;          // One-cycle pulse
  logic       rdata_valid;  // One cycle after a read grant
  sram_data_t rdata;

  modport client (
    output req, we, addr, wdata,
    input  gnt, rdata_valid, rdata
  );

  modport arb (
    input  req, we, addr, wdata,
    output gnt, rdata_valid, rdata
  );

endinterface

// Active-low chip controls as on the discrete part
interface sram_bus_if
  import sram_pkg::*;
();

  logic       cs_n;   // Chip select
  logic       oe_n;   // Output enable
  logic       w_n;    // Write enable
  sram_addr_t addr;
  sram_data_t wdata;
  sram_data_t rdata;  // Zero when not driving

  modport master (
    output cs_n, oe_n, w_n, addr, wdata,
    input  rdata
  );

  modport ram (
    input  cs_n, oe_n, w_n, addr, wdata,
    output rdata
  );

endinterface

/* hdl/sram_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types shared by RAM, arbiter and clients
// Address, byte, page number, page entry,
// client index
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "sram_consts.svh"

package sram_pkg;

  typedef logic [`SRAM_AW-1:0] sram_addr_t;  // RAM byte address
  typedef logic [`SRAM_DW-1:0] sram_data_t;  // RAM byte

  typedef logic [7:0] vpage_t;               // Virtual page number

  // Page-table entry, one byte
  typedef struct packed {
    logic       valid;  // Bit 7, entry usable
    logic [6:0] ppage;  // Physical page
  } pte_t;

  // Client index, lower value wins arbitration
  typedef enum logic {
    CLIENT_XL   = 1'b0,  // Page translator
    CLIENT_HOST = 1'b1   // Host port
  } client_e;

endpackage

/* hdl/sram_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared constants for the 2K x 8 RAM
// Address and data widths, page-table base,
// host test width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef SRAM_CONSTS_SVH
`define SRAM_CONSTS_SVH

// RAM geometry
`define SRAM_AW 11       // 2^11 bytes
`define SRAM_DW 8        // One byte per location

// Page table occupies the top 256 bytes
`define PT_BASE 11'h700  // Entry for page v at PT_BASE + v

// Bytes the host loads in the random setup phase
`define HOST_TEST_W 8

`endif
